// File: all.f
rtl/crypt_pkg.sv
rtl/flow_pkg.sv
rtl/sync_fifo.sv
rtl/block_serializer.sv
rtl/credit_tx.sv
rtl/out_cfg_regs.sv
rtl/crypt_out_top.sv
tb/crypt_out_assert.sv
tb/crypt_out_tb.sv

// File: rtl/block_serializer.sv
// ############################
// Block serializer
// Pops one ciphertext block and writes its
// sixteen bytes into the byte FIFO, last tagged
// ############################

module block_serializer
	import crypt_pkg::*;
	import flow_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  cfg_t       cfg,
	input  logic       blk_empty,
	input  block_t     blk_data,
	output logic       blk_pop,
	input  logic       byte_full,
	output logic       byte_push,
	output byte_beat_t byte_beat
);

	logic                  busy;        // Holding a block
	logic [BYTE_IDX_W-1:0] byte_idx;    // Next byte to write
	logic [BYTE_IDX_W-1:0] byte_sel;    // Block lane of that byte
	logic                  lsb_first_q; // Order frozen per block
	logic                  last_byte;
	block_t                blk_hold;

	assign last_byte = (byte_idx == BYTE_IDX_W'(BLOCK_BYTES - 1));
	assign byte_push = busy && !byte_full;

	// Next block may load on the edge that writes the last byte
	assign blk_pop = cfg.enable && !blk_empty && (!busy || (byte_push && last_byte));

	// msb-first walks down from lane 15
	assign byte_sel = lsb_first_q ? byte_idx
		: BYTE_IDX_W'(BLOCK_BYTES - 1) - byte_idx;

	always_comb begin
		byte_beat.data = blk_hold[byte_sel];
		byte_beat.last = last_byte;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy        <= 1'b0;
			byte_idx    <= '0;
			lsb_first_q <= 1'b0;
		end else if (blk_pop) begin
			busy        <= 1'b1;
			byte_idx    <= '0;
			lsb_first_q <= cfg.lsb_first; // Later writes wait for the next block
		end else if (byte_push) begin
			if (last_byte) begin
				busy     <= 1'b0;
				byte_idx <= '0;
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end
	end

	// Block payload
	always_ff @(posedge clk) begin
		if (blk_pop)
			blk_hold <= blk_data;
	end

endmodule

// File: rtl/credit_tx.sv
// ############################
// Credit-based byte transmitter
// One beat per held credit, credits
// come back from the receiver
// ############################

module credit_tx
	import crypt_pkg::*;
	import flow_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       byte_empty,
	input  byte_beat_t byte_beat,
	output logic       byte_pop,
	output logic       out_send,
	output byte_beat_t out_beat,
	input  logic       out_credit
);

	logic [CREDIT_W-1:0] credits; // Free slots at the receiver
	logic                send;

	// Pop and send are one strobe
	assign send     = !byte_empty && (credits != '0);
	assign byte_pop = send;
	assign out_send = send;
	assign out_beat = byte_beat; // FIFO head goes straight on the link

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			credits <= CREDIT_W'(OUT_CREDITS);
		end else begin
			case ({out_credit, send})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits; // Return and send cancel out
			endcase
		end
	end

endmodule

// File: rtl/crypt_out_top.sv
// ############################
// Encryptor output stage
// Block queue, serializer, byte FIFO,
// link transmitter and registers
// ############################

module crypt_out_top
	import crypt_pkg::*;
	import flow_pkg::*;
(
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  blk_send,
	input  block_t                blk_data,
	output logic                  blk_credit,
	output logic                  out_send,
	output byte_beat_t            out_beat,
	input  logic                  out_credit,
	input  logic                  cfg_we,
	input  logic [CFG_ADDR_W-1:0] cfg_addr,
	input  logic [CFG_DATA_W-1:0] cfg_wdata,
	output logic [CFG_DATA_W-1:0] cfg_rdata
);

	cfg_t       cfg;
	block_t     blk_head;
	logic       blk_pop;
	logic       blk_empty;
	logic       blk_full; // Upstream credits keep this from mattering
	byte_beat_t ser_beat;
	byte_beat_t byte_head;
	logic       byte_push;
	logic       byte_pop;
	logic       byte_empty;
	logic       byte_full;

	assign blk_credit = blk_pop; // A freed queue slot is a credit

	sync_fifo #(.item_t(block_t), .DEPTH(BLK_DEPTH)) blk_q0 (
		.clk(clk), .n_rst(n_rst),
		.push(blk_send), .wdata(blk_data),
		.pop(blk_pop), .rdata(blk_head),
		.empty(blk_empty), .full(blk_full)
	);

	block_serializer ser0 (
		.clk(clk), .n_rst(n_rst), .cfg(cfg),
		.blk_empty(blk_empty), .blk_data(blk_head), .blk_pop(blk_pop),
		.byte_full(byte_full), .byte_push(byte_push), .byte_beat(ser_beat)
	);

	sync_fifo #(.item_t(byte_beat_t), .DEPTH(BYTE_DEPTH)) byte_q0 (
		.clk(clk), .n_rst(n_rst),
		.push(byte_push), .wdata(ser_beat),
		.pop(byte_pop), .rdata(byte_head),
		.empty(byte_empty), .full(byte_full)
	);

	credit_tx tx0 (
		.clk(clk), .n_rst(n_rst),
		.byte_empty(byte_empty), .byte_beat(byte_head), .byte_pop(byte_pop),
		.out_send(out_send), .out_beat(out_beat), .out_credit(out_credit)
	);

	out_cfg_regs regs0 (
		.clk(clk), .n_rst(n_rst),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.cfg(cfg), .blk_send(blk_send), .byte_sent(out_send)
	);

endmodule

// File: rtl/crypt_pkg.sv
// ############################
// Data-path types of the encryptor output stage
// Ciphertext block, byte beat and the
// geometry of the block and byte queues
// ############################

package crypt_pkg;

	// Block geometry
	localparam int BLOCK_BYTES = 16;
	localparam int BYTE_W      = 8;
	localparam int BYTE_IDX_W  = $clog2(BLOCK_BYTES); // Byte counter inside a block

	// Queue depths
	localparam int BLK_DEPTH  = 2;  // Blocks waiting for the serializer
	localparam int BYTE_DEPTH = 16; // Bytes waiting for the link

	// Byte 15 sits in the top byte lane
	typedef logic [BLOCK_BYTES-1:0][BYTE_W-1:0] block_t;

	// One beat on the byte link
	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic              last; // Final byte of a block
	} byte_beat_t;

endpackage

// File: rtl/flow_pkg.sv
// ############################
// Flow control and configuration
// Link credits, register map and the
// control word seen by the serializer
// ############################

package flow_pkg;

	// Receiver buffer size on the byte link
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W    = 3; // Must hold OUT_CREDITS

	// Register port
	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 32;

	localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL     = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] ADDR_BLK_CNT  = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] ADDR_BYTE_CNT = 2'd2;

	// Matches bit 1 and bit 0 of the control register
	typedef struct packed {
		logic lsb_first;
		logic enable;
	} cfg_t;

endpackage

// File: rtl/out_cfg_regs.sv
// ############################
// Output stage registers
// Enable and byte order control,
// block and byte counters
// ############################

module out_cfg_regs
	import flow_pkg::*;
(
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  cfg_we,
	input  logic [CFG_ADDR_W-1:0] cfg_addr,
	input  logic [CFG_DATA_W-1:0] cfg_wdata,
	output logic [CFG_DATA_W-1:0] cfg_rdata,
	output cfg_t                  cfg,
	input  logic                  blk_send,
	input  logic                  byte_sent
);

	logic [CFG_DATA_W-1:0] blk_cnt;  // Blocks accepted
	logic [CFG_DATA_W-1:0] byte_cnt; // Bytes put on the link
	logic                  ctrl_we;

	assign ctrl_we = cfg_we && (cfg_addr == ADDR_CTRL);

	// Control register is the only writable one
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			cfg <= '0;
		else if (ctrl_we)
			cfg <= cfg_t'(cfg_wdata[$bits(cfg_t)-1:0]);
	end

	// Free-running counters that wrap at 2**32
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			blk_cnt  <= '0;
			byte_cnt <= '0;
		end else begin
			if (blk_send)
				blk_cnt <= blk_cnt + 1'b1;
			if (byte_sent)
				byte_cnt <= byte_cnt + 1'b1;
		end
	end

	// Read mux
	always_comb begin
		case (cfg_addr)
			ADDR_CTRL:     cfg_rdata = CFG_DATA_W'(cfg);
			ADDR_BLK_CNT:  cfg_rdata = blk_cnt;
			ADDR_BYTE_CNT: cfg_rdata = byte_cnt;
			default:       cfg_rdata = '0; // Unmapped
		endcase
	end

endmodule

// File: rtl/sync_fifo.sv
// ############################
// Synchronous FIFO
// Circular buffer for any payload type,
// head item visible on rdata
// ############################

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 4
) (
	input  logic  clk,
	input  logic  n_rst,
	input  logic  push,
	input  item_t wdata,
	input  logic  pop,
	output item_t rdata,
	output logic  empty,
	output logic  full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// A full FIFO still takes a push when the head leaves in the same cycle
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				// Wrap by hand so odd depths work too
				if (wr_ptr == PTR_W'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == PTR_W'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the output stage testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module crypt_out_tb \
	-Mdir obj_dir \
	-f all.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vcrypt_out_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

// File: tb/crypt_out_assert.sv
// ############################
// Output stage assertions
// Link credit bookkeeping and
// queue overflow checks on the top
// ############################

module crypt_out_assert
	import flow_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic out_send,
	input logic out_credit,
	input logic blk_send,
	input logic blk_full,
	input logic blk_pop
);

	logic [CREDIT_W:0] credit_mirror; // Spare top bit so an overrun shows

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			credit_mirror <= (CREDIT_W + 1)'(OUT_CREDITS);
		end else begin
			case ({out_credit, out_send})
				2'b10:   credit_mirror <= credit_mirror + 1'b1;
				2'b01:   credit_mirror <= credit_mirror - 1'b1;
				default: credit_mirror <= credit_mirror;
			endcase
		end
	end

	credits_in_range: assert property (@(posedge clk) disable iff (!n_rst)
		credit_mirror <= (CREDIT_W + 1)'(OUT_CREDITS))
		else $error("Link credit count above the receiver buffer size");

	send_needs_credit: assert property (@(posedge clk) disable iff (!n_rst)
		out_send |-> (credit_mirror != '0))
		else $error("Beat sent on the link with no credit left");

	blk_push_has_room: assert property (@(posedge clk) disable iff (!n_rst)
		(blk_send && blk_full) |-> blk_pop)
		else $error("Block queue written while full");

endmodule

bind crypt_out_top crypt_out_assert assert0 (
	.clk(clk), .n_rst(n_rst),
	.out_send(out_send), .out_credit(out_credit),
	.blk_send(blk_send), .blk_full(blk_full), .blk_pop(blk_pop)
);

// File: tb/crypt_out_tb.sv
// ############################
// Output stage testbench
// Random blocks from an LFSR, upstream and
// receiver credit models, byte order checks
// ############################

module crypt_out_tb
	import crypt_pkg::*;
	import flow_pkg::*;
();

	localparam int          BLOCKS_PER_RUN = 40;
	localparam int          HOLD_BLOCKS    = 3; // One in flight plus a full queue
	localparam int          TOTAL_BLOCKS   = 2 * BLOCKS_PER_RUN + HOLD_BLOCKS;
	localparam int          MAX_DELAY      = 7; // Credit delay drawn from 3 bits
	localparam int          IDLE_CYC       = 40;
	localparam int          TIMEOUT_CYC    = TOTAL_BLOCKS * BLOCK_BYTES * (MAX_DELAY + 1) + 2000;
	localparam logic [31:0] SEED           = 32'hd9d09333;

	logic                  clk;
	logic                  n_rst;
	logic                  blk_send;
	block_t                blk_data;
	logic                  blk_credit;
	logic                  out_send;
	byte_beat_t            out_beat;
	logic                  out_credit;
	logic                  cfg_we;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_wdata;
	logic [CFG_DATA_W-1:0] cfg_rdata;

	byte_beat_t  exp_q[$];     // Bytes still owed by the DUT
	int          release_q[$]; // Cycle at which each buffered beat frees its slot
	int          blk_credits;
	int          blocks_sent;
	int          credit_pulses;
	int          outstanding;  // Beats at the receiver not yet credited
	int          beats_seen;
	logic        cur_lsb;
	logic [31:0] last_ctrl;
	logic [31:0] stim_lfsr;
	logic [31:0] rx_lfsr;

	crypt_out_top dut0 (
		.clk(clk), .n_rst(n_rst),
		.blk_send(blk_send), .blk_data(blk_data), .blk_credit(blk_credit),
		.out_send(out_send), .out_beat(out_beat), .out_credit(out_credit),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v  = {v[30:0], st[0]};
			st = lfsr_step(st);
		end
	endtask

	// One clock with upstream credit bookkeeping
	task automatic tick();
		@(posedge clk);
		blk_send <= 1'b0;
		cfg_we   <= 1'b0;
		if (blk_credit) begin
			blk_credits++;
			credit_pulses++;
			assert (credit_pulses <= blocks_sent)
				else fail_run("More block credits came back than blocks were sent");
			assert (blk_credits <= BLK_DEPTH)
				else fail_run("Upstream holds more block credits than the queue depth");
		end
	endtask

	task automatic push_expected(input block_t b, input logic lsb);
		byte_beat_t            beat;
		logic [BYTE_IDX_W-1:0] lane;

		for (int k = 0; k < BLOCK_BYTES; k++) begin
			lane      = lsb ? BYTE_IDX_W'(k) : BYTE_IDX_W'(BLOCK_BYTES - 1 - k);
			beat.data = b[lane];
			beat.last = (k == BLOCK_BYTES - 1);
			exp_q.push_back(beat);
		end
	endtask

	task automatic send_blocks(input int n);
		logic [31:0] r;
		logic [31:0] w [4];
		block_t      blk;
		int          sent;

		sent = 0;
		while (sent < n) begin
			tick();
			take_bits(stim_lfsr, 1, r);
			if (r[0] && blk_credits > 0) begin
				for (int i = 0; i < 4; i++)
					take_bits(stim_lfsr, 32, w[i]);
				blk = {w[3], w[2], w[1], w[0]};
				blk_send <= 1'b1;
				blk_data <= blk;
				blk_credits--;
				blocks_sent++;
				push_expected(blk, cur_lsb); // Order at send time
				sent++;
			end
		end
	endtask

	task automatic write_ctrl(input logic [31:0] v);
		tick();
		cfg_we    <= 1'b1;
		cfg_addr  <= ADDR_CTRL;
		cfg_wdata <= v;
		last_ctrl = v;
		tick(); // Register loads on this edge
	endtask

	task automatic read_reg(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] data);
		tick();
		cfg_addr <= addr;
		tick();
		data = cfg_rdata;
	endtask

	// Everything sent has come out and all credits are home
	task automatic drain();
		while (exp_q.size() != 0 || outstanding != 0 || blk_credits != BLK_DEPTH)
			tick();
		repeat (4) tick();
	endtask

	// Receiver with OUT_CREDITS slots and random credit delays
	initial begin
		byte_beat_t  exp_beat;
		logic [31:0] r;
		int          cycle;

		out_credit <= 1'b0;
		rx_lfsr     = SEED;
		outstanding = 0;
		beats_seen  = 0;
		cycle       = 0;
		forever begin
			@(posedge clk);
			if (n_rst) begin
				outstanding = outstanding + (out_send ? 1 : 0) - (out_credit ? 1 : 0);
				assert (outstanding >= 0 && outstanding <= OUT_CREDITS)
					else fail_run($sformatf("Receiver holds %0d beats, more than it has room for",
						outstanding));
				if (out_send) begin
					assert (exp_q.size() != 0)
						else fail_run("Beat sent on the link with no byte expected");
					exp_beat = exp_q.pop_front();
					assert (out_beat.data == exp_beat.data)
						else fail_run($sformatf("FAIL out_beat.data expected %h actual %h",
							exp_beat.data, out_beat.data));
					assert (out_beat.last == ((beats_seen % BLOCK_BYTES) == BLOCK_BYTES - 1))
						else fail_run($sformatf("FAIL out_beat.last expected %h actual %h",
							exp_beat.last, out_beat.last));
					beats_seen++;
					take_bits(rx_lfsr, 3, r);
					release_q.push_back(cycle + int'(r[2:0]));
				end
				if (release_q.size() != 0 && release_q[0] <= cycle) begin
					void'(release_q.pop_front());
					out_credit <= 1'b1;
				end else begin
					out_credit <= 1'b0;
				end
				cycle++;
			end
		end
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		fail_run($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYC));
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] r;
		logic [31:0] ctrl;
		int          held;

		n_rst     <= 1'b0;
		blk_send  <= 1'b0;
		blk_data  <= '0;
		cfg_we    <= 1'b0;
		cfg_addr  <= ADDR_CTRL;
		cfg_wdata <= '0;
		stim_lfsr     = SEED;
		blk_credits   = BLK_DEPTH;
		blocks_sent   = 0;
		credit_pulses = 0;
		cur_lsb       = 1'b0;
		last_ctrl     = '0;
		repeat (4) @(posedge clk);
		n_rst <= 1'b1;

		// msb-first
		write_ctrl(32'h1);
		cur_lsb = 1'b0;
		send_blocks(BLOCKS_PER_RUN);
		drain();

		// lsb-first order set while drained
		write_ctrl(32'h3);
		cur_lsb = 1'b1;
		send_blocks(BLOCKS_PER_RUN);
		drain();

		// Enable gating with a random byte order
		take_bits(stim_lfsr, 1, r);
		ctrl = {30'd0, r[0], 1'b1};
		write_ctrl(ctrl);
		cur_lsb = r[0];
		held = beats_seen;
		send_blocks(1);
		while (beats_seen == held)
			tick();
		write_ctrl({30'd0, r[0], 1'b0}); // Block in progress still finishes
		send_blocks(HOLD_BLOCKS - 1);
		while (exp_q.size() > (HOLD_BLOCKS - 1) * BLOCK_BYTES)
			tick();
		held = beats_seen;
		repeat (IDLE_CYC) tick();
		assert (beats_seen == held)
			else fail_run("Bytes left the link while the serializer was disabled");
		assert (exp_q.size() == (HOLD_BLOCKS - 1) * BLOCK_BYTES && blk_credits == 0)
			else fail_run("Blocks sent while disabled were not held in the queue");
		write_ctrl(ctrl);
		drain();

		// Counters and control readback
		read_reg(ADDR_BLK_CNT, rd);
		assert (rd == blocks_sent && blocks_sent == TOTAL_BLOCKS)
			else fail_run($sformatf("FAIL cfg_rdata block count expected %h actual %h",
				blocks_sent, rd));
		read_reg(ADDR_BYTE_CNT, rd);
		assert (rd == blocks_sent * BLOCK_BYTES && beats_seen == blocks_sent * BLOCK_BYTES)
			else fail_run($sformatf("FAIL cfg_rdata byte count expected %h actual %h",
				blocks_sent * BLOCK_BYTES, rd));
		read_reg(ADDR_CTRL, rd);
		assert (rd == last_ctrl)
			else fail_run($sformatf("FAIL cfg_rdata control expected %h actual %h",
				last_ctrl, rd));
		assert (blk_credits == BLK_DEPTH && credit_pulses == blocks_sent)
			else fail_run("Upstream did not end with all block credits returned");

		$display("STATUS: PASS");
		$finish;
	end

endmodule
